// ==== common/dmr_config.svh ====
// DMR recovery configuration: group count, register file geometry and restore credits
`ifndef DMR_CONFIG_SVH
`define DMR_CONFIG_SVH

// Number of redundant core pairs handled by the recovery subsystem
`define DMR_NUM_GROUPS 4

// Register address width, 16 registers per group by default
`define DMR_RF_ADDR_W 4

// Register data width
`define DMR_RF_DATA_W 32

// Restore writes the core write port accepts before it returns a credit
`define DMR_RESTORE_CREDITS 2

`endif

// ==== common/dmr_recovery_pkg.sv ====
// DMR recovery package: sequencer state encoding and group index type
`default_nettype none

`include "dmr_config.svh"

package dmr_recovery_pkg;

  // Recovery routine states, in the order the routine walks through them
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    SETBACK    = 3'd1,
    HALT_REQ   = 3'd2,
    HALT_WAIT  = 3'd3,
    RESTORE_PC = 3'd4,
    RESTORE_RF = 3'd5,
    EXIT       = 3'd6
  } recovery_state_e;

  // Index of one redundant core pair
  typedef logic [$clog2(`DMR_NUM_GROUPS)-1:0] group_idx_t;

endpackage

`default_nettype wire

// ==== common/dmr_regfile_pkg.sv ====
// DMR register file package: address, data and register write types
`default_nettype none

`include "dmr_config.svh"

package dmr_regfile_pkg;

  typedef logic [`DMR_RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [`DMR_RF_DATA_W-1:0] rf_data_t;

  // One register write, used both for snooping and for the restore port
  typedef struct packed {
    logic     we;
    rf_addr_t addr;
    rf_data_t data;
  } rf_write_t;

endpackage

`default_nettype wire

// ==== common/rf_read_if.sv ====
// Backup register file read link between register restore and storage
`default_nettype none

interface rf_read_if
  import dmr_recovery_pkg::*, dmr_regfile_pkg::*;
();

  logic       rd_en;
  group_idx_t rd_group;
  rf_addr_t   rd_addr;
  // Valid one cycle after rd_en
  rf_data_t   rd_data;

  modport restore (
    output rd_en,
    output rd_group,
    output rd_addr,
    input  rd_data
  );

  modport storage (
    input  rd_en,
    input  rd_group,
    input  rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

// ==== source/dmr_error_collector.sv ====
// DMR error collector: captures the lowest faulty group and holds it until release
`default_nettype none

`include "dmr_config.svh"

module dmr_error_collector
  import dmr_recovery_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic [`DMR_NUM_GROUPS-1:0] rf_err_a_i,
  input  wire logic [`DMR_NUM_GROUPS-1:0] rf_err_b_i,
  input  wire logic [`DMR_NUM_GROUPS-1:0] core_err_main_i,
  input  wire logic [`DMR_NUM_GROUPS-1:0] core_err_data_i,
  input  wire logic                       release_i,
  output logic                            pending_o,
  output group_idx_t                      group_o
);

  logic [`DMR_NUM_GROUPS-1:0] err_vec;
  logic                       err_any;
  group_idx_t                 first_grp;
  logic                       pending_q;
  group_idx_t                 group_q;

  // Any of the four checkers flags the group as faulty
  assign err_vec = rf_err_a_i | rf_err_b_i | core_err_main_i | core_err_data_i;
  assign err_any = |err_vec;

  // Scan from the top so the lowest faulty index wins
  always_comb begin
    first_grp = '0;
    for (int i = `DMR_NUM_GROUPS - 1; i >= 0; i--) begin
      if (err_vec[i]) begin
        first_grp = group_idx_t'(i);
      end
    end
  end

  // New errors are ignored while a routine is pending
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      group_q   <= '0;
    end else if (pending_q) begin
      if (release_i) begin
        pending_q <= 1'b0;
      end
    end else if (err_any) begin
      pending_q <= 1'b1;
      group_q   <= first_grp;
    end
  end

  assign pending_o = pending_q;
  assign group_o   = group_q;

endmodule

`default_nettype wire

// ==== recovery/dmr_recovery_fsm.sv ====
// DMR recovery sequencer: walks the faulty group through setback, halt, PC and RF restore
`default_nettype none

`include "dmr_config.svh"

module dmr_recovery_fsm
  import dmr_recovery_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       pending_i,
  input  wire group_idx_t                 group_i,
  output logic                            release_o,
  input  wire logic [`DMR_NUM_GROUPS-1:0] debug_rsp_i,
  output logic      [`DMR_NUM_GROUPS-1:0] setback_o,
  output logic      [`DMR_NUM_GROUPS-1:0] clk_en_o,
  output logic      [`DMR_NUM_GROUPS-1:0] instr_lock_o,
  output logic      [`DMR_NUM_GROUPS-1:0] debug_req_o,
  output logic      [`DMR_NUM_GROUPS-1:0] debug_resume_o,
  output logic      [`DMR_NUM_GROUPS-1:0] pc_read_en_o,
  output logic      [`DMR_NUM_GROUPS-1:0] pc_write_en_o,
  output logic      [`DMR_NUM_GROUPS-1:0] recover_o,
  output logic                            restore_start_o,
  input  wire logic                       restore_done_i,
  output group_idx_t                      restore_group_o
);

  recovery_state_e            state_q, state_d;
  logic                       pc_cnt_q, pc_cnt_d;
  logic [`DMR_NUM_GROUPS-1:0] lock_q, lock_d;
  logic [`DMR_NUM_GROUPS-1:0] clk_en_q, clk_en_d;
  logic [`DMR_NUM_GROUPS-1:0] pc_we_q, pc_we_d;
  logic [`DMR_NUM_GROUPS-1:0] recover_q, recover_d;

  always_comb begin
    state_d         = state_q;
    pc_cnt_d        = pc_cnt_q;
    lock_d          = lock_q;
    clk_en_d        = clk_en_q;
    pc_we_d         = pc_we_q;
    recover_d       = recover_q;
    setback_o       = '0;
    debug_req_o     = '0;
    debug_resume_o  = '0;
    pc_read_en_o    = '0;
    release_o       = 1'b0;
    restore_start_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (pending_i) begin
          state_d = SETBACK;
        end
      end
      SETBACK: begin
        // Freeze the rest of the cluster and keep the faulty PC backup stable
        setback_o[group_i] = 1'b1;
        lock_d[group_i]    = 1'b1;
        pc_we_d[group_i]   = 1'b0;
        clk_en_d           = '0;
        clk_en_d[group_i]  = 1'b1;
        state_d            = HALT_REQ;
      end
      HALT_REQ: begin
        debug_req_o[group_i] = 1'b1;
        state_d              = HALT_WAIT;
      end
      HALT_WAIT: begin
        if (debug_rsp_i[group_i]) begin
          state_d = RESTORE_PC;
        end
      end
      RESTORE_PC: begin
        // Two cycles give the PC readback time to settle in the core
        pc_read_en_o[group_i] = 1'b1;
        pc_cnt_d              = ~pc_cnt_q;
        if (pc_cnt_q) begin
          state_d = RESTORE_RF;
        end
      end
      RESTORE_RF: begin
        restore_start_o    = 1'b1;
        recover_d[group_i] = 1'b1;
        if (restore_done_i) begin
          debug_resume_o[group_i] = 1'b1;
          lock_d[group_i]         = 1'b0;
          state_d                 = EXIT;
        end
      end
      EXIT: begin
        release_o = 1'b1;
        lock_d    = '0;
        clk_en_d  = '1;
        pc_we_d   = '1;
        recover_d = '0;
        state_d   = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      pc_cnt_q  <= 1'b0;
      lock_q    <= '0;
      clk_en_q  <= '1;
      pc_we_q   <= '1;
      recover_q <= '0;
    end else begin
      state_q   <= state_d;
      pc_cnt_q  <= pc_cnt_d;
      lock_q    <= lock_d;
      clk_en_q  <= clk_en_d;
      pc_we_q   <= pc_we_d;
      recover_q <= recover_d;
    end
  end

  assign instr_lock_o    = lock_q;
  assign clk_en_o        = clk_en_q;
  assign pc_write_en_o   = pc_we_q;
  assign recover_o       = recover_q;
  // The collector holds the group stable for the whole routine
  assign restore_group_o = group_i;

endmodule

`default_nettype wire

// ==== recovery/dmr_rf_restore.sv ====
// DMR register restore: replays backed-up registers into the core under credit control
`default_nettype none

`include "dmr_config.svh"

module dmr_rf_restore
  import dmr_recovery_pkg::*, dmr_regfile_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       start_i,
  input  wire group_idx_t group_i,
  output logic            done_o,
  rf_read_if.restore      rd,
  output rf_write_t       restore_wr_o,
  input  wire logic       credit_i
);

  localparam int unsigned credit_w = $clog2(`DMR_RESTORE_CREDITS + 1);

  // Extra top bit marks that every register has been read
  logic [`DMR_RF_ADDR_W:0] cnt_q;
  logic [credit_w-1:0]     credit_q;
  logic                    rd_issue;
  logic                    wr_valid_q;
  rf_addr_t                wr_addr_q;

  assign rd_issue = start_i && !cnt_q[`DMR_RF_ADDR_W] && (credit_q != '0);

  assign rd.rd_en    = rd_issue;
  assign rd.rd_group = group_i;
  assign rd.rd_addr  = cnt_q[`DMR_RF_ADDR_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      credit_q <= credit_w'(`DMR_RESTORE_CREDITS);
    end else if (!start_i) begin
      cnt_q    <= '0;
      credit_q <= credit_w'(`DMR_RESTORE_CREDITS);
    end else begin
      if (rd_issue) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // A read and a returned credit in the same cycle cancel out
      if (rd_issue && !credit_i) begin
        credit_q <= credit_q - 1'b1;
      end else if (!rd_issue && credit_i) begin
        credit_q <= credit_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= rd_issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_issue) begin
      wr_addr_q <= rd.rd_addr;
    end
  end

  // The read data arrives together with the delayed address
  assign restore_wr_o.we   = wr_valid_q;
  assign restore_wr_o.addr = wr_addr_q;
  assign restore_wr_o.data = rd.rd_data;

  assign done_o = wr_valid_q && (wr_addr_q == '1);

endmodule

`default_nettype wire

// ==== source/dmr_backup_rf.sv ====
// DMR backup register file: snoops core register writes per group and serves restore reads
`default_nettype none

`include "dmr_config.svh"

module dmr_backup_rf
  import dmr_regfile_pkg::*;
(
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire rf_write_t [`DMR_NUM_GROUPS-1:0] snoop_i,
  input  wire logic      [`DMR_NUM_GROUPS-1:0] snoop_en_i,
  rf_read_if.storage                           rd
);

  localparam int unsigned num_regs = 2 ** `DMR_RF_ADDR_W;

  rf_data_t mem_q [`DMR_NUM_GROUPS][num_regs];
  rf_data_t rd_data_q;

  // Snooping stops for a group while its PC write enable is low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else begin
      for (int g = 0; g < `DMR_NUM_GROUPS; g++) begin
        if (snoop_en_i[g] && snoop_i[g].we) begin
          mem_q[g][snoop_i[g].addr] <= snoop_i[g].data;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd.rd_en) begin
      rd_data_q <= mem_q[rd.rd_group][rd.rd_addr];
    end
  end

  assign rd.rd_data = rd_data_q;

endmodule

`default_nettype wire

// ==== source/dmr_recovery_top.sv ====
// DMR recovery subsystem top: error collection, sequencer, register restore and backup RF
`default_nettype none

`include "dmr_config.svh"

module dmr_recovery_top
  import dmr_recovery_pkg::*, dmr_regfile_pkg::*;
(
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic      [`DMR_NUM_GROUPS-1:0] rf_err_a_i,
  input  wire logic      [`DMR_NUM_GROUPS-1:0] rf_err_b_i,
  input  wire logic      [`DMR_NUM_GROUPS-1:0] core_err_main_i,
  input  wire logic      [`DMR_NUM_GROUPS-1:0] core_err_data_i,
  input  wire rf_write_t [`DMR_NUM_GROUPS-1:0] backup_wr_i,
  output logic           [`DMR_NUM_GROUPS-1:0] setback_o,
  output logic           [`DMR_NUM_GROUPS-1:0] clk_en_o,
  output logic           [`DMR_NUM_GROUPS-1:0] instr_lock_o,
  output logic           [`DMR_NUM_GROUPS-1:0] debug_req_o,
  input  wire logic      [`DMR_NUM_GROUPS-1:0] debug_rsp_i,
  output logic           [`DMR_NUM_GROUPS-1:0] debug_resume_o,
  output logic           [`DMR_NUM_GROUPS-1:0] pc_read_en_o,
  output logic           [`DMR_NUM_GROUPS-1:0] pc_write_en_o,
  output logic           [`DMR_NUM_GROUPS-1:0] recover_o,
  output rf_write_t                            restore_wr_o,
  output group_idx_t                           restore_group_o,
  input  wire logic                            restore_credit_i
);

  logic       pending;
  group_idx_t err_group;
  logic       release_pulse;
  logic       restore_start;
  logic       restore_done;
  group_idx_t seq_group;

  rf_read_if i_rf_read_if ();

  dmr_error_collector i_error_collector (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rf_err_a_i      (rf_err_a_i),
    .rf_err_b_i      (rf_err_b_i),
    .core_err_main_i (core_err_main_i),
    .core_err_data_i (core_err_data_i),
    .release_i       (release_pulse),
    .pending_o       (pending),
    .group_o         (err_group)
  );

  dmr_recovery_fsm i_recovery_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pending_i       (pending),
    .group_i         (err_group),
    .release_o       (release_pulse),
    .debug_rsp_i     (debug_rsp_i),
    .setback_o       (setback_o),
    .clk_en_o        (clk_en_o),
    .instr_lock_o    (instr_lock_o),
    .debug_req_o     (debug_req_o),
    .debug_resume_o  (debug_resume_o),
    .pc_read_en_o    (pc_read_en_o),
    .pc_write_en_o   (pc_write_en_o),
    .recover_o       (recover_o),
    .restore_start_o (restore_start),
    .restore_done_i  (restore_done),
    .restore_group_o (seq_group)
  );

  dmr_rf_restore i_rf_restore (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (restore_start),
    .group_i      (seq_group),
    .done_o       (restore_done),
    .rd           (i_rf_read_if.restore),
    .restore_wr_o (restore_wr_o),
    .credit_i     (restore_credit_i)
  );

  // The PC write enable also gates snooping of the faulty group
  dmr_backup_rf i_backup_rf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .snoop_i    (backup_wr_i),
    .snoop_en_i (pc_write_en_o),
    .rd         (i_rf_read_if.storage)
  );

  assign restore_group_o = seq_group;

endmodule

`default_nettype wire

// ==== dv/tb_dmr_recovery.sv ====
// Random-stimulus testbench for the DMR recovery subsystem against a shadow register file model
`default_nettype none

`include "dmr_config.svh"

module tb_dmr_recovery
  import dmr_recovery_pkg::*, dmr_regfile_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int num_groups     = `DMR_NUM_GROUPS;
  localparam int num_regs       = 2 ** `DMR_RF_ADDR_W;
  localparam int credits        = `DMR_RESTORE_CREDITS;
  localparam int num_recoveries = 8;

  logic                  clk_i;
  logic                  rst_ni;
  logic [num_groups-1:0] rf_err_a_i;
  logic [num_groups-1:0] rf_err_b_i;
  logic [num_groups-1:0] core_err_main_i;
  logic [num_groups-1:0] core_err_data_i;
  rf_write_t [num_groups-1:0] backup_wr_i;
  logic [num_groups-1:0] setback_o;
  logic [num_groups-1:0] clk_en_o;
  logic [num_groups-1:0] instr_lock_o;
  logic [num_groups-1:0] debug_req_o;
  logic [num_groups-1:0] debug_rsp_i;
  logic [num_groups-1:0] debug_resume_o;
  logic [num_groups-1:0] pc_read_en_o;
  logic [num_groups-1:0] pc_write_en_o;
  logic [num_groups-1:0] recover_o;
  rf_write_t             restore_wr_o;
  group_idx_t            restore_group_o;
  logic                  restore_credit_i;

  logic [31:0]           rng_state;
  logic [31:0]           crd_state;
  rf_data_t              shadow [num_groups][num_regs];
  int                    exp_grp;
  logic [num_groups-1:0] exp_mask;
  int                    exp_addr;
  int                    err_cnt;
  int                    check_cnt;
  int                    setback_cnt;
  int                    req_cnt;
  int                    resume_cnt;
  int                    pc_read_cnt;
  int                    wr_cnt;
  int                    outstanding;
  logic                  timed_out;

  always #50 clk_i = ~clk_i;

  dmr_recovery_top i_dmr_recovery_top (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .rf_err_a_i       (rf_err_a_i),
    .rf_err_b_i       (rf_err_b_i),
    .core_err_main_i  (core_err_main_i),
    .core_err_data_i  (core_err_data_i),
    .backup_wr_i      (backup_wr_i),
    .setback_o        (setback_o),
    .clk_en_o         (clk_en_o),
    .instr_lock_o     (instr_lock_o),
    .debug_req_o      (debug_req_o),
    .debug_rsp_i      (debug_rsp_i),
    .debug_resume_o   (debug_resume_o),
    .pc_read_en_o     (pc_read_en_o),
    .pc_write_en_o    (pc_write_en_o),
    .recover_o        (recover_o),
    .restore_wr_o     (restore_wr_o),
    .restore_group_o  (restore_group_o),
    .restore_credit_i (restore_credit_i)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Random group set that always holds at least one group
  function automatic logic [num_groups-1:0] random_mask();
    logic [31:0]           r;
    logic [num_groups-1:0] m;
    r = next_rand();
    m = r[num_groups-1:0];
    m[r[15:8] % num_groups] = 1'b1;
    return m;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error: %s got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic end_run();
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    err_cnt++;
    timed_out = 1'b1;
    $display("Timed out waiting for %s at %0t", what, $time);
  endtask

  task automatic check_idle();
    check_val("clk_en_o", clk_en_o, {num_groups{1'b1}});
    check_val("pc_write_en_o", pc_write_en_o, {num_groups{1'b1}});
    check_val("instr_lock_o", instr_lock_o, 64'h0);
    check_val("setback_o", setback_o, 64'h0);
    check_val("debug_req_o", debug_req_o, 64'h0);
    check_val("debug_resume_o", debug_resume_o, 64'h0);
    check_val("pc_read_en_o", pc_read_en_o, 64'h0);
    check_val("recover_o", recover_o, 64'h0);
    check_val("restore_wr_o.we", restore_wr_o.we, 64'h0);
  endtask

  task automatic drive_writes(input logic routine);
    rf_write_t   wr;
    logic [31:0] r;
    for (int g = 0; g < num_groups; g++) begin
      r       = next_rand();
      wr.we   = r[0];
      wr.addr = r[8 +: `DMR_RF_ADDR_W];
      wr.data = rf_data_t'(next_rand());
      backup_wr_i[g] = wr;
      // Snooping of the faulty group is frozen for the whole routine
      if (wr.we && !(routine && g == exp_grp)) begin
        shadow[g][wr.addr] = wr.data;
      end
    end
  endtask

  task automatic inject_errors(input logic [num_groups-1:0] mask);
    logic [31:0] r;
    for (int g = 0; g < num_groups; g++) begin
      r = next_rand();
      if (mask[g]) begin
        case (r[1:0])
          2'd0:    rf_err_a_i[g] = 1'b1;
          2'd1:    rf_err_b_i[g] = 1'b1;
          2'd2:    core_err_main_i[g] = 1'b1;
          default: core_err_data_i[g] = 1'b1;
        endcase
      end
    end
  endtask

  task automatic clear_errors();
    rf_err_a_i      = '0;
    rf_err_b_i      = '0;
    core_err_main_i = '0;
    core_err_data_i = '0;
  endtask

  task automatic run_recovery();
    logic [num_groups-1:0] err_mask;
    logic [num_groups-1:0] others;
    int                    n;
    int                    delay;
    @(negedge clk_i);
    setback_cnt = 0;
    req_cnt     = 0;
    resume_cnt  = 0;
    pc_read_cnt = 0;
    wr_cnt      = 0;
    exp_addr    = 0;
    n = 4 + next_rand() % 12;
    repeat (n) begin
      drive_writes(1'b0);
      @(posedge clk_i);
      check_idle();
      @(negedge clk_i);
    end
    backup_wr_i = '0;
    // Several groups may fail at once, the lowest index is recovered
    err_mask = random_mask();
    exp_grp  = num_groups;
    for (int g = 0; g < num_groups; g++) begin
      if (err_mask[g] && exp_grp == num_groups) begin
        exp_grp = g;
      end
    end
    exp_mask = '0;
    exp_mask[exp_grp] = 1'b1;
    others = ~exp_mask;
    inject_errors(err_mask);
    @(negedge clk_i);
    clear_errors();
    n = 0;
    @(posedge clk_i);
    while (setback_o == '0 && n < 8) begin
      @(posedge clk_i);
      n++;
    end
    if (setback_o == '0) begin
      report_timeout("setback_o");
      return;
    end
    @(posedge clk_i);
    check_val("debug_req_o", debug_req_o, exp_mask);
    check_val("instr_lock_o", instr_lock_o, exp_mask);
    check_val("clk_en_o", clk_en_o, exp_mask);
    check_val("pc_write_en_o", pc_write_en_o, others);
    // New errors during the routine must not start another one
    delay = next_rand() % 6;
    @(negedge clk_i);
    drive_writes(1'b1);
    inject_errors(random_mask());
    repeat (delay) begin
      @(posedge clk_i);
      @(negedge clk_i);
      clear_errors();
      drive_writes(1'b1);
    end
    debug_rsp_i = exp_mask;
    @(posedge clk_i);
    check_val("pc_read_en_o", pc_read_en_o, 64'h0);
    @(negedge clk_i);
    debug_rsp_i = '0;
    clear_errors();
    drive_writes(1'b1);
    repeat (2) begin
      @(posedge clk_i);
      check_val("pc_read_en_o", pc_read_en_o, exp_mask);
      @(negedge clk_i);
      drive_writes(1'b1);
    end
    @(posedge clk_i);
    check_val("pc_read_en_o", pc_read_en_o, 64'h0);
    check_val("recover_o", recover_o, 64'h0);
    n = 0;
    while (debug_resume_o == '0 && n < 600) begin
      @(negedge clk_i);
      drive_writes(1'b1);
      @(posedge clk_i);
      check_val("recover_o", recover_o, exp_mask);
      n++;
    end
    if (debug_resume_o == '0) begin
      report_timeout("debug_resume_o");
      return;
    end
    @(negedge clk_i);
    backup_wr_i = '0;
    @(posedge clk_i);
    check_val("instr_lock_o", instr_lock_o, 64'h0);
    check_val("recover_o", recover_o, exp_mask);
    check_val("clk_en_o", clk_en_o, exp_mask);
    @(posedge clk_i);
    check_idle();
    @(negedge clk_i);
    check_val("setback_o pulse count", setback_cnt, 1);
    check_val("debug_req_o pulse count", req_cnt, 1);
    check_val("debug_resume_o pulse count", resume_cnt, 1);
    check_val("pc_read_en_o cycle count", pc_read_cnt, 2);
    check_val("restore_wr_o write count", wr_cnt, num_regs);
    n = 0;
    while (outstanding != 0 && n < 100) begin
      @(negedge clk_i);
      n++;
    end
    if (outstanding != 0) begin
      report_timeout("returned restore credits");
    end
  endtask

  // Core write port model: returns one credit per accepted write after a random delay
  always @(negedge clk_i) begin
    if (rst_ni && outstanding > 0) begin
      crd_state = xorshift32(crd_state);
      restore_credit_i = (crd_state[1:0] == 2'b00);
    end else begin
      restore_credit_i = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (setback_o != '0) begin
        setback_cnt++;
        check_val("setback_o", setback_o, exp_mask);
      end
      if (debug_req_o != '0) begin
        req_cnt++;
        check_val("debug_req_o", debug_req_o, exp_mask);
      end
      if (debug_resume_o != '0) begin
        resume_cnt++;
        check_val("debug_resume_o", debug_resume_o, exp_mask);
      end
      if (pc_read_en_o != '0) begin
        pc_read_cnt++;
        check_val("pc_read_en_o", pc_read_en_o, exp_mask);
      end
      if (restore_wr_o.we) begin
        check_val("restore_wr_o.addr", restore_wr_o.addr, exp_addr);
        check_val("restore_wr_o.data", restore_wr_o.data, shadow[exp_grp][exp_addr % num_regs]);
        check_val("restore_group_o", restore_group_o, exp_grp);
        exp_addr++;
        wr_cnt++;
        outstanding++;
      end
      if (restore_credit_i) begin
        outstanding--;
      end
      if (outstanding > credits) begin
        err_cnt++;
        $display("Restore port holds %0d outstanding writes, more than the %0d credits allow",
                 outstanding, credits);
      end
    end
  end

  initial begin
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    backup_wr_i      = '0;
    debug_rsp_i      = '0;
    restore_credit_i = 1'b0;
    clear_errors();
    rng_state   = 32'h5213;
    crd_state   = next_rand();
    err_cnt     = 0;
    check_cnt   = 0;
    setback_cnt = 0;
    req_cnt     = 0;
    resume_cnt  = 0;
    pc_read_cnt = 0;
    wr_cnt      = 0;
    outstanding = 0;
    timed_out   = 1'b0;
    exp_grp     = 0;
    exp_mask    = '0;
    exp_addr    = 0;
    foreach (shadow[g, a]) begin
      shadow[g][a] = '0;
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (4) begin
      @(posedge clk_i);
      check_idle();
    end
    for (int i = 0; i < num_recoveries && !timed_out; i++) begin
      run_recovery();
    end
    if (!timed_out) begin
      // A late routine started by an ignored error would show up here
      repeat (6) begin
        @(posedge clk_i);
        check_idle();
      end
    end
    end_run();
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
common/dmr_recovery_pkg.sv
common/dmr_regfile_pkg.sv
common/rf_read_if.sv
source/dmr_error_collector.sv
recovery/dmr_recovery_fsm.sv
recovery/dmr_rf_restore.sv
source/dmr_backup_rf.sv
source/dmr_recovery_top.sv
dv/tb_dmr_recovery.sv

// ==== Bender.yml ====
package:
  name: dmr_recovery

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/dmr_recovery_pkg.sv
      - common/dmr_regfile_pkg.sv
      - common/rf_read_if.sv
      - source/dmr_error_collector.sv
      - recovery/dmr_recovery_fsm.sv
      - recovery/dmr_rf_restore.sv
      - source/dmr_backup_rf.sv
      - source/dmr_recovery_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_dmr_recovery.sv
